//--- logic/evhdr_delay_timer.sv
`timescale 1ns/10ps
`default_nettype none

module evhdr_delay_timer (
    input  wire  sysclk_i,
    input  wire  runrst_i,
    input  wire  trig_i,
    input  wire  shift_start_i,
    output logic window_done_o,
    output logic run_done_o
);

    evhdr_pkg::tmr_cnt_t win_cnt;
    evhdr_pkg::tmr_cnt_t run_cnt;

    // window counter: reloaded by every trigger, idles at zero
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            win_cnt <= '0;
        end else if (trig_i) begin
            win_cnt <= evhdr_pkg::WIN_LOAD;
        end else if (win_cnt != '0) begin
            win_cnt <= win_cnt - 1'b1;
        end
    end

    // word run counter, started when the sequencer leaves META_WAIT
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            run_cnt <= '0;
        end else if (shift_start_i) begin
            run_cnt <= evhdr_pkg::RUN_LOAD;
        end else if (run_cnt != '0) begin
            run_cnt <= run_cnt - 1'b1;
        end
    end

    // trigger at T loads 15 at T+1, so a count of one lands on T+15
    assign window_done_o = (win_cnt == evhdr_pkg::tmr_cnt_t'(1));

    // one during the twelfth META_WRITE cycle
    assign run_done_o = (run_cnt == evhdr_pkg::tmr_cnt_t'(1));

endmodule

`default_nettype wire

//--- logic/evhdr_meta_collect.sv
`timescale 1ns/10ps
`default_nettype none

module evhdr_meta_collect (
    input  wire                                   sysclk_i,
    input  wire                                   runrst_i,
    input  wire                                   trig_i,
    input  wire                                   window_done_i,
    input  wire evhdr_pkg::hdr_state_e            state_i,
    input  wire [evhdr_pkg::META_TOTAL_W-1:0]     metadata_i,
    output logic [evhdr_pkg::DATA_W-1:0]          meta_word_o
);

    logic [evhdr_pkg::META_TOTAL_W-1:0] meta_hold;
    logic [evhdr_pkg::NUM_META-1:0]     meta_valid;
    logic                               in_window;
    logic                               capture;

    // the trigger cycle already counts as part of the window
    assign capture = in_window || trig_i;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            in_window <= 1'b0;
        end else if (trig_i) begin
            in_window <= 1'b1;
        end else if (window_done_i) begin
            in_window <= 1'b0;
        end
    end

    // per slot: sticky once a nonzero byte has been seen
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            meta_valid <= '0;
        end else begin
            for (int m = 0; m < evhdr_pkg::NUM_META; m++) begin
                if (!capture) begin
                    meta_valid[m] <= 1'b0;
                end else if (metadata_i[m*evhdr_pkg::META_W +: evhdr_pkg::META_W] != '0) begin
                    meta_valid[m] <= 1'b1;
                end
            end
        end
    end

    // holding register follows the inputs until each slot locks,
    // then drains one word per cycle with zero fill
    always_ff @(posedge sysclk_i) begin
        if (capture) begin
            for (int m = 0; m < evhdr_pkg::NUM_META; m++) begin
                if (!meta_valid[m]) begin
                    meta_hold[m*evhdr_pkg::META_W +: evhdr_pkg::META_W] <=
                        metadata_i[m*evhdr_pkg::META_W +: evhdr_pkg::META_W];
                end
            end
        end else if (state_i == evhdr_pkg::META_WRITE) begin
            meta_hold <= {
                {evhdr_pkg::DATA_W{1'b0}},
                meta_hold[evhdr_pkg::META_TOTAL_W-1:evhdr_pkg::DATA_W]
            };
        end
    end

    // slot 0 sits in the low byte of the first word
    assign meta_word_o = meta_hold[evhdr_pkg::DATA_W-1:0];

endmodule

`default_nettype wire

//--- logic/evhdr_out_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module evhdr_out_fifo (
    input  wire                              sysclk_i,
    input  wire                              runrst_i,
    input  wire                              flush_i,
    input  wire                              wr_en_i,
    input  wire [evhdr_pkg::DATA_W-1:0]      wr_data_i,
    input  wire                              wr_last_i,
    input  wire                              rd_ready_i,
    output logic [evhdr_pkg::DATA_W-1:0]     rd_data_o,
    output logic                             rd_last_o,
    output logic                             rd_valid_o
);

    // last flag rides above the data
    logic [evhdr_pkg::DATA_W:0] mem [evhdr_pkg::FIFO_DEPTH];

    evhdr_pkg::fifo_ptr_t wr_ptr;
    evhdr_pkg::fifo_ptr_t rd_ptr;
    evhdr_pkg::fifo_cnt_t count;

    logic out_free;
    logic mem_empty;
    logic load_mem;
    logic bypass;
    logic mem_wr;

    assign out_free  = !rd_valid_o || rd_ready_i;
    assign mem_empty = (count == '0);
    assign load_mem  = out_free && !mem_empty;
    // empty buffer and a free output: skip the array for one-cycle latency
    assign bypass    = out_free && mem_empty && wr_en_i;
    // a full buffer silently drops the word
    assign mem_wr    = wr_en_i && !bypass && (count != evhdr_pkg::FIFO_FULL);

    always_ff @(posedge sysclk_i) begin
        if (mem_wr) begin
            mem[wr_ptr] <= {wr_last_i, wr_data_i};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + evhdr_pkg::fifo_cnt_t'(mem_wr) - evhdr_pkg::fifo_cnt_t'(load_mem);
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || flush_i) begin
            rd_valid_o <= 1'b0;
        end else if (out_free) begin
            rd_valid_o <= load_mem || bypass;
        end
    end

    // head register only moves once the current word is taken
    always_ff @(posedge sysclk_i) begin
        if (load_mem) begin
            {rd_last_o, rd_data_o} <= mem[rd_ptr];
        end else if (bypass) begin
            {rd_last_o, rd_data_o} <= {wr_last_i, wr_data_i};
        end
    end

endmodule

`default_nettype wire

//--- logic/evhdr_pkg.sv
`default_nettype none

package evhdr_pkg;

    // header word and metadata geometry
    localparam int DATA_W = 64;
    localparam int NUM_META = 32;
    localparam int META_W = 8;
    localparam int META_TOTAL_W = NUM_META * META_W;

    // window includes the trigger cycle itself
    localparam int META_WINDOW = 16;

    // metadata phase: real words, then zero words shifted out of the same register
    localparam int META_QWORDS = META_TOTAL_W / DATA_W;
    localparam int RSVD_QWORDS = 8;
    localparam int META_RUN = META_QWORDS + RSVD_QWORDS;

    // header shorts remaining after the first one
    localparam logic [15:0] CONST_HEADER_WORDS = 16'd63;
    localparam logic [15:0] CONST_EVENT_FORMAT = "E1";
    // trailing shorts announced in the last word
    localparam logic [15:0] CONST_SURF_WORDS = 16'd64;

    localparam int RUNCFG_W = 12;
    localparam int TIO_W = 4;

    // output FIFO sizing
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0] fifo_cnt_t;
    localparam fifo_cnt_t FIFO_FULL = fifo_cnt_t'(FIFO_DEPTH);

    // delay timer counters, wide enough for both loads
    localparam int TMR_W = 4;
    typedef logic [TMR_W-1:0] tmr_cnt_t;
    localparam tmr_cnt_t WIN_LOAD = tmr_cnt_t'(META_WINDOW - 1);
    localparam tmr_cnt_t RUN_LOAD = tmr_cnt_t'(META_RUN);

    typedef enum logic [2:0] {
        IDLE,
        EVENT_COUNT,
        CUR_TIME,
        PPS_HOLD,
        META_WAIT,
        META_WRITE,
        TRAILER
    } hdr_state_e;

endpackage

`default_nettype wire

//--- logic/evhdr_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module evhdr_sequencer (
    input  wire                    sysclk_i,
    input  wire                    runrst_i,
    input  wire                    runstop_i,
    input  wire                    trig_i,
    input  wire                    window_done_i,
    input  wire                    run_done_i,
    output evhdr_pkg::hdr_state_e  state_o,
    output logic                   shift_start_o,
    output logic [31:0]            event_count_o,
    output logic                   event_o,
    output logic                   wr_en_o,
    output logic                   wr_last_o,
    output logic                   running_o
);

    evhdr_pkg::hdr_state_e state;
    logic                  running;
    logic                  window_complete;
    logic [31:0]           event_count;

    // runrst_i doubles as the run start
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            running <= 1'b1;
        end else if (runstop_i) begin
            running <= 1'b0;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || trig_i) begin
            window_complete <= 1'b0;
        end else if (window_done_i) begin
            window_complete <= 1'b1;
        end
    end

    assign shift_start_o = (state == evhdr_pkg::META_WAIT) && window_complete;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || !running) begin
            state <= evhdr_pkg::IDLE;
        end else begin
            case (state)
                evhdr_pkg::IDLE: begin
                    if (trig_i) begin
                        state <= evhdr_pkg::EVENT_COUNT;
                    end
                end
                evhdr_pkg::EVENT_COUNT: state <= evhdr_pkg::CUR_TIME;
                evhdr_pkg::CUR_TIME:    state <= evhdr_pkg::PPS_HOLD;
                evhdr_pkg::PPS_HOLD:    state <= evhdr_pkg::META_WAIT;
                evhdr_pkg::META_WAIT: begin
                    if (window_complete) begin
                        state <= evhdr_pkg::META_WRITE;
                    end
                end
                evhdr_pkg::META_WRITE: begin
                    if (run_done_i) begin
                        state <= evhdr_pkg::TRAILER;
                    end
                end
                evhdr_pkg::TRAILER: state <= evhdr_pkg::IDLE;
                default:            state <= evhdr_pkg::IDLE;
            endcase
        end
    end

    // word 0 carries the count before this increment
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            event_count <= '0;
        end else if (state == evhdr_pkg::EVENT_COUNT) begin
            event_count <= event_count + 1'b1;
        end
    end

    // registered so they line up with the word builder output
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            event_o   <= 1'b0;
            wr_en_o   <= 1'b0;
            wr_last_o <= 1'b0;
        end else begin
            event_o   <= running && (state == evhdr_pkg::EVENT_COUNT);
            wr_en_o   <= running && (state != evhdr_pkg::IDLE) &&
                         (state != evhdr_pkg::META_WAIT);
            wr_last_o <= running && (state == evhdr_pkg::TRAILER);
        end
    end

    assign state_o       = state;
    assign event_count_o = event_count;
    assign running_o     = running;

endmodule

`default_nettype wire

//--- logic/evhdr_top.sv
`timescale 1ns/10ps
`default_nettype none

module evhdr_top (
    input  wire                               sysclk_i,
    input  wire                               runrst_i,
    input  wire                               runstop_i,
    input  wire                               trig_i,
    input  wire [evhdr_pkg::TIO_W-1:0]        tio_mask_i,
    input  wire [evhdr_pkg::RUNCFG_W-1:0]     runcfg_i,
    input  wire [evhdr_pkg::META_TOTAL_W-1:0] metadata_i,
    input  wire [31:0]                        cur_sec_i,
    input  wire [31:0]                        cur_time_i,
    input  wire [31:0]                        last_pps_i,
    input  wire [31:0]                        llast_pps_i,
    input  wire                               m_hdr_tready_i,
    output logic                              event_o,
    output logic [evhdr_pkg::DATA_W-1:0]      m_hdr_tdata_o,
    output logic                              m_hdr_tvalid_o,
    output logic                              m_hdr_tlast_o
);

    evhdr_pkg::hdr_state_e           state;
    logic                            window_done;
    logic                            run_done;
    logic                            shift_start;
    logic [31:0]                     event_count;
    logic                            wr_en;
    logic                            wr_last;
    logic                            running;
    logic [evhdr_pkg::DATA_W-1:0]    meta_word;
    logic [evhdr_pkg::DATA_W-1:0]    hdr_word;

    evhdr_delay_timer u_timer (
        .sysclk_i      (sysclk_i),
        .runrst_i      (runrst_i),
        .trig_i        (trig_i),
        .shift_start_i (shift_start),
        .window_done_o (window_done),
        .run_done_o    (run_done)
    );

    evhdr_meta_collect u_meta (
        .sysclk_i      (sysclk_i),
        .runrst_i      (runrst_i),
        .trig_i        (trig_i),
        .window_done_i (window_done),
        .state_i       (state),
        .metadata_i    (metadata_i),
        .meta_word_o   (meta_word)
    );

    evhdr_sequencer u_seq (
        .sysclk_i      (sysclk_i),
        .runrst_i      (runrst_i),
        .runstop_i     (runstop_i),
        .trig_i        (trig_i),
        .window_done_i (window_done),
        .run_done_i    (run_done),
        .state_o       (state),
        .shift_start_o (shift_start),
        .event_count_o (event_count),
        .event_o       (event_o),
        .wr_en_o       (wr_en),
        .wr_last_o     (wr_last),
        .running_o     (running)
    );

    evhdr_word_builder u_build (
        .sysclk_i      (sysclk_i),
        .runrst_i      (runrst_i),
        .state_i       (state),
        .event_count_i (event_count),
        .cur_sec_i     (cur_sec_i),
        .cur_time_i    (cur_time_i),
        .last_pps_i    (last_pps_i),
        .llast_pps_i   (llast_pps_i),
        .tio_mask_i    (tio_mask_i),
        .runcfg_i      (runcfg_i),
        .meta_word_i   (meta_word),
        .word_o        (hdr_word)
    );

    // stopping the run throws away anything not yet read
    evhdr_out_fifo u_fifo (
        .sysclk_i      (sysclk_i),
        .runrst_i      (runrst_i),
        .flush_i       (!running),
        .wr_en_i       (wr_en),
        .wr_data_i     (hdr_word),
        .wr_last_i     (wr_last),
        .rd_ready_i    (m_hdr_tready_i),
        .rd_data_o     (m_hdr_tdata_o),
        .rd_last_o     (m_hdr_tlast_o),
        .rd_valid_o    (m_hdr_tvalid_o)
    );

endmodule

`default_nettype wire

//--- logic/evhdr_word_builder.sv
`timescale 1ns/10ps
`default_nettype none

module evhdr_word_builder (
    input  wire                               sysclk_i,
    input  wire                               runrst_i,
    input  wire evhdr_pkg::hdr_state_e        state_i,
    input  wire [31:0]                        event_count_i,
    input  wire [31:0]                        cur_sec_i,
    input  wire [31:0]                        cur_time_i,
    input  wire [31:0]                        last_pps_i,
    input  wire [31:0]                        llast_pps_i,
    input  wire [evhdr_pkg::TIO_W-1:0]        tio_mask_i,
    input  wire [evhdr_pkg::RUNCFG_W-1:0]     runcfg_i,
    input  wire [evhdr_pkg::DATA_W-1:0]       meta_word_i,
    output logic [evhdr_pkg::DATA_W-1:0]      word_o
);

    logic [31:0] cur_sec_hold;
    logic [31:0] cur_time_hold;
    logic [31:0] last_pps_hold;
    logic [31:0] llast_pps_hold;
    logic [evhdr_pkg::TIO_W+evhdr_pkg::RUNCFG_W-1:0] run_cfg;

    // event time is taken a cycle after the trigger, which is close enough
    always_ff @(posedge sysclk_i) begin
        if (state_i == evhdr_pkg::EVENT_COUNT) begin
            cur_sec_hold   <= cur_sec_i;
            cur_time_hold  <= cur_time_i;
            last_pps_hold  <= last_pps_i;
            llast_pps_hold <= llast_pps_i;
        end
    end

    // configuration is fixed for the whole run
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            run_cfg <= {tio_mask_i, runcfg_i};
        end
    end

    // word layout
    //   0      count | format | header shorts
    //   1      time | seconds
    //   2      second-last pps | last pps
    //   3-14   metadata then zeros
    //   15     surf shorts | config | zero
    always_ff @(posedge sysclk_i) begin
        case (state_i)
            evhdr_pkg::EVENT_COUNT: begin
                word_o <= {event_count_i, evhdr_pkg::CONST_EVENT_FORMAT,
                           evhdr_pkg::CONST_HEADER_WORDS};
            end
            evhdr_pkg::CUR_TIME: begin
                word_o <= {cur_time_hold, cur_sec_hold};
            end
            evhdr_pkg::PPS_HOLD: begin
                word_o <= {llast_pps_hold, last_pps_hold};
            end
            evhdr_pkg::META_WRITE: begin
                word_o <= meta_word_i;
            end
            evhdr_pkg::TRAILER: begin
                word_o <= {evhdr_pkg::CONST_SURF_WORDS, run_cfg, 32'h0000_0000};
            end
            default: begin
                word_o <= word_o;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the event header testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module tb_evhdr \
    -f src.f \
    && ./obj_dir/Vtb_evhdr | tee /dev/stderr | grep -q -F '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
logic/evhdr_pkg.sv
logic/evhdr_delay_timer.sv
logic/evhdr_meta_collect.sv
logic/evhdr_sequencer.sv
logic/evhdr_word_builder.sv
logic/evhdr_out_fifo.sv
logic/evhdr_top.sv
tb/tb_evhdr.sv

//--- tb/tb_evhdr.sv
`timescale 1ns/10ps
`default_nettype none

module tb_evhdr;

    localparam int RUN1_EVENTS = 10;
    localparam int FLUSH_EVENTS = 1;
    localparam int STOP_TRIGGERS = 2;
    localparam int RUN2_EVENTS = 6;
    localparam int TRIGGERS = RUN1_EVENTS + FLUSH_EVENTS + STOP_TRIGGERS + RUN2_EVENTS;
    // roughly 55 cycles per trigger plus reset and drain time
    localparam int LIMIT_CYCLES = TRIGGERS * 60 + 300;

    logic         sysclk_i = 1'b0;
    logic         runrst_i;
    logic         runstop_i;
    logic         trig_i;
    logic [3:0]   tio_mask_i;
    logic [11:0]  runcfg_i;
    logic [255:0] metadata_i = '0;
    logic [31:0]  cur_sec_i = 32'h0000_0100;
    logic [31:0]  cur_time_i = 32'h1000_0000;
    logic [31:0]  last_pps_i = 32'h0fff_ffe0;
    logic [31:0]  llast_pps_i = 32'h0fff_ffc0;
    logic         m_hdr_tready_i = 1'b0;
    logic         event_o;
    logic [63:0]  m_hdr_tdata_o;
    logic         m_hdr_tvalid_o;
    logic         m_hdr_tlast_o;

    logic [31:0]  rng_state = 32'd83018;
    logic         stall_ready = 1'b0;

    // reference model state
    logic [64:0]  exp_q[$];
    logic         running_m = 1'b0;
    logic [31:0]  event_num = '0;
    logic [15:0]  run_cfg_m = '0;
    logic         ev_d1 = 1'b0;
    logic         ev_d2 = 1'b0;
    logic         win_active = 1'b0;
    int           win_pos = 0;
    logic [31:0]  meta_seen = '0;
    logic [255:0] meta_exp = '0;
    logic [31:0]  prev_sec = '0;
    logic [31:0]  prev_time = '0;
    logic [31:0]  prev_last = '0;
    logic [31:0]  prev_llast = '0;
    logic         hold_pending = 1'b0;
    logic [64:0]  hold_word = '0;
    logic         flush_pending = 1'b0;

    int           err_value = 0;
    int           err_other = 0;
    int           events_seen = 0;
    int           words_taken = 0;

    evhdr_top dut_i (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .runstop_i      (runstop_i),
        .trig_i         (trig_i),
        .tio_mask_i     (tio_mask_i),
        .runcfg_i       (runcfg_i),
        .metadata_i     (metadata_i),
        .cur_sec_i      (cur_sec_i),
        .cur_time_i     (cur_time_i),
        .last_pps_i     (last_pps_i),
        .llast_pps_i    (llast_pps_i),
        .m_hdr_tready_i (m_hdr_tready_i),
        .event_o        (event_o),
        .m_hdr_tdata_o  (m_hdr_tdata_o),
        .m_hdr_tvalid_o (m_hdr_tvalid_o),
        .m_hdr_tlast_o  (m_hdr_tlast_o)
    );

    always #50 sysclk_i = ~sysclk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // free-running inputs: ready, metadata and time counters
    always @(posedge sysclk_i) begin
        #1;
        rng_state = lcg_next(rng_state);
        m_hdr_tready_i = !stall_ready && (rng_state[31:30] != 2'b00);
        for (int m = 0; m < 32; m++) begin
            rng_state = lcg_next(rng_state);
            if (rng_state[31:29] == 3'b000) begin
                metadata_i[m*8 +: 8] = rng_state[23:16] % 8'd255 + 8'd1;
            end else begin
                metadata_i[m*8 +: 8] = 8'h00;
            end
        end
        cur_time_i = cur_time_i + 32'd1;
        // a pps tick every 32 cycles
        if (cur_time_i[4:0] == 5'd0) begin
            llast_pps_i = last_pps_i;
            last_pps_i = cur_time_i;
            cur_sec_i = cur_sec_i + 32'd1;
        end
    end

    task automatic check_stream();
        logic [64:0] want;
        if (hold_pending) begin
            assert (m_hdr_tvalid_o) else begin
                err_other++;
                $display("valid dropped before the word was taken at %0t", $time);
            end
            assert ({m_hdr_tlast_o, m_hdr_tdata_o} == hold_word) else begin
                err_value++;
                $display("FAILED %0t m_hdr_tdata_o got %h expected %h (held)",
                         $time, {m_hdr_tlast_o, m_hdr_tdata_o}, hold_word);
            end
        end
        if (m_hdr_tvalid_o) begin
            assert (exp_q.size() != 0) else begin
                err_other++;
                $display("a word appeared on the stream when none was expected at %0t", $time);
            end
            if (m_hdr_tready_i && exp_q.size() != 0) begin
                want = exp_q.pop_front();
                words_taken++;
                assert (m_hdr_tdata_o == want[63:0]) else begin
                    err_value++;
                    $display("FAILED %0t m_hdr_tdata_o got %h expected %h",
                             $time, m_hdr_tdata_o, want[63:0]);
                end
                assert (m_hdr_tlast_o == want[64]) else begin
                    err_value++;
                    $display("FAILED %0t m_hdr_tlast_o got %b expected %b",
                             $time, m_hdr_tlast_o, want[64]);
                end
            end
        end
        hold_pending = m_hdr_tvalid_o && !m_hdr_tready_i;
        hold_word = {m_hdr_tlast_o, m_hdr_tdata_o};
    endtask

    task automatic update_model();
        logic [7:0] b;
        int         m;
        int         w;
        assert (event_o == ev_d2) else begin
            err_value++;
            $display("FAILED %0t event_o got %b expected %b", $time, event_o, ev_d2);
        end
        // time values were latched one cycle before event_o
        if (event_o) begin
            exp_q.push_back({1'b0, event_num, 16'h4531, 16'd63});
            exp_q.push_back({1'b0, prev_time, prev_sec});
            exp_q.push_back({1'b0, prev_llast, prev_last});
            event_num = event_num + 32'd1;
            events_seen++;
        end
        if (trig_i && running_m) begin
            win_active = 1'b1;
            win_pos = 0;
            meta_seen = '0;
            meta_exp = '0;
        end
        if (win_active) begin
            for (m = 0; m < 32; m++) begin
                b = metadata_i[m*8 +: 8];
                if (!meta_seen[m] && b != 8'h00) begin
                    meta_seen[m] = 1'b1;
                    meta_exp[m*8 +: 8] = b;
                end
            end
            if (win_pos == 15) begin
                for (w = 0; w < 12; w++) begin
                    if (w < 4) begin
                        exp_q.push_back({1'b0, meta_exp[w*64 +: 64]});
                    end else begin
                        exp_q.push_back(65'd0);
                    end
                end
                exp_q.push_back({1'b1, 16'd64, run_cfg_m, 32'd0});
                win_active = 1'b0;
            end else begin
                win_pos++;
            end
        end
        ev_d2 = ev_d1;
        ev_d1 = trig_i && running_m;
        if (runstop_i) begin
            running_m = 1'b0;
            exp_q.delete();
            flush_pending = 1'b1;
        end
    endtask

    // model and checks run where all signals are settled
    always @(negedge sysclk_i) begin
        if (runrst_i) begin
            running_m = 1'b1;
            event_num = '0;
            run_cfg_m = {tio_mask_i, runcfg_i};
            ev_d1 = 1'b0;
            ev_d2 = 1'b0;
            win_active = 1'b0;
            hold_pending = 1'b0;
            flush_pending = 1'b0;
            exp_q.delete();
        end else begin
            if (flush_pending) begin
                // the output register clears one cycle after running drops
                flush_pending = 1'b0;
                hold_pending = 1'b0;
            end else begin
                check_stream();
            end
            update_model();
        end
        prev_sec = cur_sec_i;
        prev_time = cur_time_i;
        prev_last = last_pps_i;
        prev_llast = llast_pps_i;
    end

    task automatic start_run(input logic [3:0] tio, input logic [11:0] cfg);
        tio_mask_i = tio;
        runcfg_i = cfg;
        runrst_i = 1'b1;
        repeat (5) @(posedge sysclk_i);
        #1;
        runrst_i = 1'b0;
    endtask

    task automatic fire_trigger(input int gap);
        @(posedge sysclk_i);
        #1;
        trig_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        trig_i = 1'b0;
        repeat (gap) @(posedge sysclk_i);
        #1;
    endtask

    task automatic stop_run();
        @(posedge sysclk_i);
        #1;
        runstop_i = 1'b1;
        @(posedge sysclk_i);
        #1;
        runstop_i = 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge sysclk_i);
        #1;
        while (exp_q.size() != 0 || m_hdr_tvalid_o) begin
            @(posedge sysclk_i);
            #1;
        end
    endtask

    task automatic check_quiet_outputs(input string when);
        assert (!event_o && !m_hdr_tvalid_o) else begin
            err_other++;
            $display("event_o or m_hdr_tvalid_o high %s at %0t", when, $time);
        end
    endtask

    initial begin
        runstop_i = 1'b0;
        trig_i = 1'b0;
        start_run(4'hA, 12'h5C3);
        check_quiet_outputs("after the first reset");
        for (int i = 0; i < RUN1_EVENTS; i++) begin
            fire_trigger(40 + (i * 7) % 13);
        end
        wait_drained();
        // a record left waiting behind a stalled consumer, so the stop has to flush it
        stall_ready = 1'b1;
        for (int i = 0; i < FLUSH_EVENTS; i++) begin
            fire_trigger(40);
        end
        stop_run();
        repeat (2) @(posedge sysclk_i);
        #1;
        check_quiet_outputs("after the run stop");
        stall_ready = 1'b0;
        // triggers with the run stopped must stay silent
        for (int i = 0; i < STOP_TRIGGERS; i++) begin
            fire_trigger(40);
        end
        start_run(4'h3, 12'h0E9);
        check_quiet_outputs("after the restart");
        for (int i = 0; i < RUN2_EVENTS; i++) begin
            fire_trigger(40 + (i * 5) % 11);
        end
        wait_drained();
        assert (events_seen == RUN1_EVENTS + FLUSH_EVENTS + RUN2_EVENTS) else begin
            err_other++;
            $display("saw %0d event pulses but %0d triggers were issued in running state",
                     events_seen, RUN1_EVENTS + FLUSH_EVENTS + RUN2_EVENTS);
        end
        assert (words_taken == 16 * (RUN1_EVENTS + RUN2_EVENTS)) else begin
            err_other++;
            $display("only %0d header words were taken from the stream", words_taken);
        end
        $display("errors: %0d value, %0d other, %0d words checked",
                 err_value, err_other, words_taken);
        if (err_value == 0 && err_other == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 100);
        $display("watchdog expired before the test sequence finished");
        $display("errors: %0d value, %0d other, %0d words checked",
                 err_value, err_other, words_taken);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
